//--- logic/aw_hold_fsm.sv
// ----------------------------------------------------------------------
// Holds one write address, asks for its translation and issues it with
// the physical page swapped in once the allow pulse has been seen
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module aw_hold_fsm
   import stall_wr_pkg::*;
(
   input  logic        clk,
   input  logic        rst,

   // CPU side
   input  aw_req_t     s_aw,
   input  logic        s_awvalid,
   output logic        s_awready,

   // Memory side
   output aw_req_t     m_aw,
   output logic        m_awvalid,
   input  logic        m_awready,

   // Translation engine
   input  xlat_rsp_t   xlat,
   output lookup_req_t lookup,

   output hold_state_t state
);

   hold_state_t state_q;
   hold_state_t state_d;

   aw_req_t req_q;
   aw_req_t req_d;

   logic s_awready_q;
   logic s_awready_d;
   logic m_awvalid_q;
   logic m_awvalid_d;
   logic allow_q;
   logic allow_d;

   logic aw_fire;

   assign aw_fire = s_awvalid & s_awready_q;

   always_comb begin
      state_d     = state_q;
      req_d       = req_q;
      s_awready_d = s_awready_q;
      allow_d     = allow_q;
      // Issued address stays up until the memory side takes it
      m_awvalid_d = m_awvalid_q & ~m_awready;

      case (state_q)
         hold_idle: begin
            // Only one address in flight
            s_awready_d = ~m_awvalid_q;
            if (aw_fire) begin
               req_d       = s_aw;
               s_awready_d = 1'b0;
               // New request waits for a fresh allow
               allow_d     = 1'b0;
               state_d     = hold_wait_xlat;
            end
         end

         hold_wait_xlat: begin
            s_awready_d = 1'b0;
            if (allow_q) begin
               // Swap in the physical page, keep the 4 KB offset
               req_d.addr  = {xlat.ppa, req_q.addr[page_shift-1:0]};
               m_awvalid_d = 1'b1;
               state_d     = hold_idle;
            end
         end

         default: begin
            state_d = hold_idle;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q     <= hold_idle;
         s_awready_q <= 1'b0;
         m_awvalid_q <= 1'b0;
         allow_q     <= 1'b0;
      end else begin
         state_q     <= state_d;
         s_awready_q <= s_awready_d;
         m_awvalid_q <= m_awvalid_d;
         // Allow pulse wins over the clear
         if (xlat.allow_access) begin
            allow_q <= 1'b1;
         end else begin
            allow_q <= allow_d;
         end
      end
   end

   // Held request, payload only
   always_ff @(posedge clk) begin
      req_q <= req_d;
   end

   assign s_awready = s_awready_q;
   assign m_awvalid = m_awvalid_q;
   assign m_aw      = req_q;
   assign state     = state_q;

   // Lookup drops as soon as an allow is seen or remembered
   assign lookup.valid = (state_q == hold_wait_xlat) & ~(xlat.allow_access | allow_q);
   assign lookup.hppa  = req_q.addr[addr_w-1:page_shift];

endmodule

//--- logic/stall_wr_pkg.sv
// ----------------------------------------------------------------------
// Shared widths, AXI channel structs, FSM states and helpers for the
// write-address stall unit; imported by every design module
// ----------------------------------------------------------------------
package stall_wr_pkg;

   localparam int addr_w     = 40;
   localparam int data_w     = 64;
   localparam int strb_w     = 8;
   localparam int id_w       = 4;
   localparam int count_w    = 16;
   localparam int page_shift = 12;

   typedef logic [addr_w-1:0]            addr_t;
   typedef logic [data_w-1:0]            data_t;
   typedef logic [strb_w-1:0]            strb_t;
   typedef logic [id_w-1:0]              id_t;
   typedef logic [count_w-1:0]           count_t;
   typedef logic [addr_w-page_shift-1:0] page_t;

   // Everything below this address is the translation table
   localparam addr_t table_limit = 40'h00_0080_0000;

   // AXI write response code for a good completion
   localparam logic [1:0] resp_okay = 2'b00;

   typedef struct packed {
      id_t        id;
      addr_t      addr;
      logic [7:0] len;
      logic [2:0] size;
      logic [1:0] burst;
      logic       lock;
      logic [3:0] cache;
      logic [2:0] prot;
      logic [3:0] qos;
      logic [3:0] region;
   } aw_req_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } w_beat_t;

   typedef struct packed {
      id_t        id;
      logic [1:0] resp;
   } b_resp_t;

   // Request towards the translation engine
   typedef struct packed {
      logic  valid;
      page_t hppa;
   } lookup_req_t;

   // Answer from the translation engine
   typedef struct packed {
      logic  allow_access;
      page_t ppa;
   } xlat_rsp_t;

   typedef enum logic [0:0] {
      hold_idle,
      hold_wait_xlat
   } hold_state_t;

   typedef struct packed {
      addr_t       last_addr0;
      addr_t       last_addr1;
      count_t      req_count0;
      count_t      resp_count0;
      count_t      req_count1;
      count_t      resp_count1;
      logic        overflow;
      logic        bus_error;
      logic        illegal_table_access;
      hold_state_t fsm_state;
   } stall_dbg_t;

   // Mirror the strobe so lane 0 lands on the top bit
   function automatic strb_t reverse_strb(input strb_t strb);
      strb_t rev;
      for (int i = 0; i < strb_w; i++) begin
         rev[i] = strb[strb_w-1-i];
      end
      return rev;
   endfunction

endpackage

//--- logic/stall_wr_top.sv
// ----------------------------------------------------------------------
// Write-port stall unit; AW goes through the hold FSM, W and B pass
// straight through, and the monitor drives the debug bus
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stall_wr_top
   import stall_wr_pkg::*;
(
   input  logic        clk,
   input  logic        rst,

   // CPU side AW
   input  aw_req_t     s_aw,
   input  logic        s_awvalid,
   output logic        s_awready,

   // Memory side AW
   output aw_req_t     m_aw,
   output logic        m_awvalid,
   input  logic        m_awready,

   // W channel
   input  w_beat_t     s_w,
   input  logic        s_wvalid,
   output logic        s_wready,
   output w_beat_t     m_w,
   output logic        m_wvalid,
   input  logic        m_wready,

   // B channel
   input  b_resp_t     m_b,
   input  logic        m_bvalid,
   output logic        m_bready,
   output b_resp_t     s_b,
   output logic        s_bvalid,
   input  logic        s_bready,

   // Translation engine
   output lookup_req_t lookup,
   input  xlat_rsp_t   xlat,

   output stall_dbg_t  dbg
);

   hold_state_t hold_state;

   logic aw_fire;
   logic m_aw_fire;
   logic b_fire;

   assign aw_fire   = s_awvalid & s_awready;
   assign m_aw_fire = m_awvalid & m_awready;
   assign b_fire    = s_bvalid & s_bready;

   aw_hold_fsm u_hold (
      .clk       (clk),
      .rst       (rst),
      .s_aw      (s_aw),
      .s_awvalid (s_awvalid),
      .s_awready (s_awready),
      .m_aw      (m_aw),
      .m_awvalid (m_awvalid),
      .m_awready (m_awready),
      .xlat      (xlat),
      .lookup    (lookup),
      .state     (hold_state)
   );

   txn_monitor u_mon (
      .clk       (clk),
      .rst       (rst),
      .s_aw      (s_aw),
      .aw_fire   (aw_fire),
      .s_b       (s_b),
      .b_fire    (b_fire),
      .m_aw_addr (m_aw.addr),
      .m_aw_fire (m_aw_fire),
      .state     (hold_state),
      .dbg       (dbg)
   );

   // W forwarded with the strobe lanes mirrored for the memory side
   assign m_w.data = s_w.data;
   assign m_w.strb = reverse_strb(s_w.strb);
   assign m_w.last = s_w.last;
   assign m_wvalid = s_wvalid;
   assign s_wready = m_wready;

   // B returned untouched
   assign s_b      = m_b;
   assign s_bvalid = m_bvalid;
   assign m_bready = s_bready;

endmodule

//--- logic/txn_monitor.sv
// ----------------------------------------------------------------------
// Passive monitor of the stall unit; per-ID counters, last addresses
// and sticky error flags presented on the debug bus
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module txn_monitor
   import stall_wr_pkg::*;
(
   input  logic        clk,
   input  logic        rst,

   input  aw_req_t     s_aw,
   input  logic        aw_fire,
   input  b_resp_t     s_b,
   input  logic        b_fire,
   input  addr_t       m_aw_addr,
   input  logic        m_aw_fire,
   input  hold_state_t state,

   output stall_dbg_t  dbg
);

   addr_t  last_addr0;
   addr_t  last_addr1;
   count_t req_count0;
   count_t req_count1;
   count_t resp_count0;
   count_t resp_count1;

   logic overflow;
   logic bus_error;
   logic illegal_table_access;
   hold_state_t state_q;

   logic cnt_full;
   logic bad_id;

   // Any counter pinned at all ones
   assign cnt_full = (&req_count0) | (&resp_count0) | (&req_count1) | (&resp_count1);

   // Only IDs 0 and 1 are tracked
   assign bad_id = (aw_fire & (s_aw.id > id_t'(1))) | (b_fire & (s_b.id > id_t'(1)));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         last_addr0  <= '1;
         last_addr1  <= '1;
         req_count0  <= '0;
         req_count1  <= '0;
         resp_count0 <= '0;
         resp_count1 <= '0;
         overflow    <= 1'b0;
         bus_error   <= 1'b0;
      end else begin
         overflow <= overflow | cnt_full | bad_id;

         if (aw_fire) begin
            if (s_aw.id == id_t'(0)) begin
               last_addr0 <= s_aw.addr;
               req_count0 <= req_count0 + count_t'(1);
            end else if (s_aw.id == id_t'(1)) begin
               last_addr1 <= s_aw.addr;
               req_count1 <= req_count1 + count_t'(1);
            end
         end

         if (b_fire) begin
            if (s_b.resp != resp_okay) begin
               bus_error <= 1'b1;
            end else if (s_b.id == id_t'(0)) begin
               resp_count0 <= resp_count0 + count_t'(1);
            end else if (s_b.id == id_t'(1)) begin
               resp_count1 <= resp_count1 + count_t'(1);
            end
         end
      end
   end

   // Issued address landing inside the translation table
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         illegal_table_access <= 1'b0;
      end else if (m_aw_fire && (m_aw_addr < table_limit)) begin
         illegal_table_access <= 1'b1;
      end
   end

   // FSM state, delayed to line up with the other fields
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= hold_idle;
      end else begin
         state_q <= state;
      end
   end

   assign dbg.last_addr0           = last_addr0;
   assign dbg.last_addr1           = last_addr1;
   assign dbg.req_count0           = req_count0;
   assign dbg.resp_count0          = resp_count0;
   assign dbg.req_count1           = req_count1;
   assign dbg.resp_count1          = resp_count1;
   assign dbg.overflow             = overflow;
   assign dbg.bus_error            = bus_error;
   assign dbg.illegal_table_access = illegal_table_access;
   assign dbg.fsm_state            = state_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the stall unit testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module stall_wr_tb -Mdir obj_dir -o sim

./obj_dir/sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without failure"

//--- src.f
logic/stall_wr_pkg.sv
logic/aw_hold_fsm.sv
logic/txn_monitor.sv
logic/stall_wr_top.sv
verif/stall_wr_asserts.sv
verif/stall_wr_tb.sv

//--- verif/stall_wr_asserts.sv
// ----------------------------------------------------------------------
// Concurrent checks bound into the stall unit top level, with a small
// reference model of the capture, remap and debug counters
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stall_wr_asserts
   import stall_wr_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input aw_req_t     s_aw,
   input aw_req_t     m_aw,
   input logic        s_awvalid, s_awready, m_awvalid, m_awready,
   input w_beat_t     s_w,
   input w_beat_t     m_w,
   input logic        s_wvalid, s_wready, m_wvalid, m_wready,
   input b_resp_t     m_b,
   input b_resp_t     s_b,
   input logic        m_bvalid, m_bready, s_bvalid, s_bready,
   input lookup_req_t lookup,
   input xlat_rsp_t   xlat,
   input stall_dbg_t  dbg,
   input hold_state_t hold_state
);

   aw_req_t     cap_q;
   aw_req_t     prev_aw;
   aw_req_t     exp_aw;
   page_t       ppa_q;
   logic        allow_m;
   lookup_req_t exp_lk;
   w_beat_t     exp_w;
   stall_dbg_t  exp_dbg;

   int n_remap = 0, n_lookup = 0, n_hold = 0, n_ready = 0, n_pass = 0, n_dbg = 0;
   int err_count;

   assign err_count = n_remap + n_lookup + n_hold + n_ready + n_pass + n_dbg;

   always_comb begin
      exp_aw      = cap_q;
      exp_aw.addr = {ppa_q, cap_q.addr[11:0]};
      exp_lk      = {1'b1, cap_q.addr[39:12]};
      exp_w       = s_w;
      // Lane order flipped end to end
      exp_w.strb  = {<<{s_w.strb}};
   end

   always_ff @(posedge clk) begin
      prev_aw <= m_aw;
      if (s_awvalid && s_awready) begin
         cap_q <= s_aw;
      end
      if (xlat.allow_access) begin
         ppa_q <= xlat.ppa;
      end
   end

   // Expected debug bus, one cycle behind each observed event
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         allow_m            <= 1'b0;
         exp_dbg            <= '0;
         exp_dbg.last_addr0 <= '1;
         exp_dbg.last_addr1 <= '1;
      end else begin
         exp_dbg.fsm_state <= hold_state;
         if (xlat.allow_access) begin
            allow_m <= 1'b1;
         end else if (s_awvalid && s_awready) begin
            allow_m <= 1'b0;
         end
         if (s_awvalid && s_awready && s_aw.id == 4'd0) begin
            exp_dbg.last_addr0 <= s_aw.addr;
            exp_dbg.req_count0 <= exp_dbg.req_count0 + 16'd1;
         end
         if (s_awvalid && s_awready && s_aw.id == 4'd1) begin
            exp_dbg.last_addr1 <= s_aw.addr;
            exp_dbg.req_count1 <= exp_dbg.req_count1 + 16'd1;
         end
         if (s_bvalid && s_bready) begin
            if (s_b.resp != 2'b00) begin
               exp_dbg.bus_error <= 1'b1;
            end else if (s_b.id == 4'd0) begin
               exp_dbg.resp_count0 <= exp_dbg.resp_count0 + 16'd1;
            end else if (s_b.id == 4'd1) begin
               exp_dbg.resp_count1 <= exp_dbg.resp_count1 + 16'd1;
            end
         end
         // Below 8 MB is the translation table
         if (m_awvalid && m_awready && m_aw.addr < 40'h00_0080_0000) begin
            exp_dbg.illegal_table_access <= 1'b1;
         end
      end
   end

   remap_chk: assert property (@(posedge clk) disable iff (rst) $rose(m_awvalid) |-> m_aw == exp_aw)
      else begin
         n_remap++;
         $error("ERR remap expected %h actual %h", $sampled(exp_aw), $sampled(m_aw));
      end

   // No issue and a live lookup until an allow shows up
   lookup_chk: assert property (@(posedge clk) disable iff (rst)
      (hold_state == hold_wait_xlat && !allow_m && !xlat.allow_access)
         |-> {m_awvalid, lookup} == {1'b0, exp_lk})
      else begin
         n_lookup++;
         $error("ERR lookup expected %h actual %h", $sampled({1'b0, exp_lk}),
                $sampled({m_awvalid, lookup}));
      end

   aw_hold_chk: assert property (@(posedge clk) disable iff (rst)
      m_awvalid && !m_awready |=> m_awvalid && m_aw == prev_aw)
      else begin
         n_hold++;
         $error("ERR aw_hold expected %h actual %h", $sampled({1'b1, prev_aw}),
                $sampled({m_awvalid, m_aw}));
      end

   aw_ready_chk: assert property (@(posedge clk) disable iff (rst) m_awvalid |-> !s_awready)
      else begin
         n_ready++;
         $error("ERR aw_ready expected %h actual %h", 1'b0, $sampled(s_awready));
      end

   pass_chk: assert property (@(posedge clk) disable iff (rst)
      {m_w, m_wvalid, s_wready, s_b, s_bvalid, m_bready}
         == {exp_w, s_wvalid, m_wready, m_b, m_bvalid, s_bready})
      else begin
         n_pass++;
         $error("ERR pass_through expected %h actual %h",
                $sampled({exp_w, s_wvalid, m_wready, m_b, m_bvalid, s_bready}),
                $sampled({m_w, m_wvalid, s_wready, s_b, s_bvalid, m_bready}));
      end

   dbg_chk: assert property (@(posedge clk) disable iff (rst) dbg == exp_dbg)
      else begin
         n_dbg++;
         $error("ERR debug_bus expected %h actual %h", $sampled(exp_dbg), $sampled(dbg));
      end

endmodule

//--- verif/stall_wr_tb.sv
// ----------------------------------------------------------------------
// Testbench for the write-address stall unit; random AW, W and B traffic
// plus a translation engine, checked by the bound assertions
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module stall_wr_tb
   import stall_wr_pkg::*;
();

   logic        clk;
   logic        rst;
   aw_req_t     s_aw;
   aw_req_t     m_aw;
   logic        s_awvalid, s_awready, m_awvalid, m_awready;
   w_beat_t     s_w;
   w_beat_t     m_w;
   logic        s_wvalid, s_wready, m_wvalid, m_wready;
   b_resp_t     m_b;
   b_resp_t     s_b;
   logic        m_bvalid, m_bready, s_bvalid, s_bready;
   lookup_req_t lookup;
   xlat_rsp_t   xlat;
   stall_dbg_t  dbg;

   integer seed;
   integer w_seed;

   stall_wr_top dut0 (.*);

   bind stall_wr_top stall_wr_asserts chk0 (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(negedge clk) begin
      if (dut0.chk0.err_count != 0) begin
         $display("sim failed");
         $fatal(1, "assertion failure seen");
      end
   end

   // Free running W traffic
   always @(negedge clk) begin
      if (rst == 1'b0) begin
         s_w      = {$random(w_seed), $random(w_seed), 8'($random(w_seed)), 1'($random(w_seed))};
         s_wvalid = 1'($random(w_seed));
         m_wready = 1'($random(w_seed));
      end
   end

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("sim failed");
      $fatal(1, "timeout");
   endtask

   task automatic send_aw(input id_t id, input addr_t addr);
      int          n;
      logic [95:0] rnd;
      n         = 0;
      rnd       = {$random(seed), $random(seed), $random(seed)};
      s_aw      = rnd[$bits(aw_req_t)-1:0];
      s_aw.id   = id;
      s_aw.addr = addr;
      s_awvalid = 1'b1;
      while (!s_awready) begin
         @(negedge clk);
         n++;
         if (n > 50) report_timeout("s_awready");
      end
      @(negedge clk);
      s_awvalid = 1'b0;
   endtask

   // Allow pulse after a delay, ppa held until the next pulse
   task automatic give_allow(input page_t ppa, input int delay);
      repeat (delay) @(negedge clk);
      xlat = {1'b1, ppa};
      @(negedge clk);
      xlat.allow_access = 1'b0;
   endtask

   task automatic take_aw(input int stall, output id_t id);
      int n;
      n = 0;
      while (!m_awvalid) begin
         @(negedge clk);
         n++;
         if (n > 50) report_timeout("m_awvalid");
      end
      id = m_aw.id;
      repeat (stall) @(negedge clk);
      m_awready = 1'b1;
      @(negedge clk);
      m_awready = 1'b0;
   endtask

   task automatic send_b(input id_t id, input logic [1:0] resp, input int delay);
      m_b      = {id, resp};
      m_bvalid = 1'b1;
      repeat (delay) @(negedge clk);
      s_bready = 1'b1;
      @(negedge clk);
      m_bvalid = 1'b0;
      s_bready = 1'b0;
   endtask

   initial begin
      addr_t addr;
      page_t ppa;
      id_t   id;
      id_t   bid;
      seed      = 63882;
      w_seed    = 63882;
      rst       = 1'b1;
      s_aw      = '0;
      s_awvalid = 1'b0;
      m_awready = 1'b0;
      s_w       = '0;
      s_wvalid  = 1'b0;
      m_wready  = 1'b0;
      m_b       = '0;
      m_bvalid  = 1'b0;
      s_bready  = 1'b0;
      xlat      = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      for (int i = 0; i < 16; i++) begin
         id   = 4'($random(seed) & 1);
         addr = {8'($random(seed)), 32'($random(seed))};
         ppa  = {1'b1, 27'($random(seed))};
         // One page at zero lands in the translation table
         if (i == 9) ppa = '0;
         send_aw(id, addr);
         give_allow(ppa, $unsigned($random(seed)) % 4);
         take_aw($unsigned($random(seed)) % 4, bid);
         send_b(bid, (i == 5) ? 2'b10 : 2'b00, $unsigned($random(seed)) % 3);
      end

      repeat (4) @(negedge clk);
      if (dut0.chk0.err_count != 0) begin
         $display("sim failed");
         $fatal(1, "assertion failure seen");
      end else begin
         $display("sim passed");
         $finish;
      end
   end

endmodule
